/* rtl/ahbAddrDecoder.sv */
// Address decoder with per-slave select and data-phase read-data mux
`timescale 1ns/1ps
`default_nettype none

`include "ahbMacros.svh"

module ahbAddrDecoder (
    input  wire logic                  HCLK,
    input  wire logic                  reset,
    input  wire ahbPkg::ahbAddrPhase_t addrPhase,
    output logic                       HSELRam,
    output logic                       HSELIo,
    input  wire logic [31:0]           HRDATARam,
    input  wire logic [31:0]           HRDATAIo,
    output logic [31:0]                HRDATA
);

    logic ioRegion;
    logic dataSelIo;

    // Bit 31 splits RAM from IO
    assign ioRegion = (addrPhase.HADDR & `IO_BASE) != '0;

    assign HSELRam = addrPhase.HSEL & ~ioRegion;
    assign HSELIo  = addrPhase.HSEL & ioRegion;

    // Remember the slave for the following data phase
    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataSelIo <= 1'b0;
        end else if (addrPhase.HSEL & addrPhase.HTRANS) begin
            dataSelIo <= ioRegion;
        end
    end

    assign HRDATA = dataSelIo ? HRDATAIo : HRDATARam;

endmodule

`default_nettype wire

/* rtl/ahbArbiter.sv */
// Two-master round-robin arbiter driving the shared address phase and write data
`timescale 1ns/1ps
`default_nettype none

module ahbArbiter (
    input  wire logic                  HCLK,
    input  wire logic                  reset,
    input  wire ahbPkg::masterReq_t    req0,
    input  wire ahbPkg::masterReq_t    req1,
    output logic                       grant0,
    output logic                       grant1,
    output logic                       rdValid0,
    output logic                       rdValid1,
    output ahbPkg::ahbAddrPhase_t      addrPhase,
    output logic [31:0]                HWDATA
);

    // Set when master 1 had the last grant
    logic lastGrant1;

    // Data-phase owner, write bit and activity
    logic dataActive;
    logic dataOwner;
    logic dataWrite;

    // Contention goes to the master not granted last
    assign grant0 = req0.valid & (~req1.valid | lastGrant1);
    assign grant1 = req1.valid & (~req0.valid | ~lastGrant1);

    always_comb begin
        addrPhase.HSEL   = grant0 | grant1;
        addrPhase.HTRANS = grant0 | grant1;
        addrPhase.HWRITE = grant1 ? req1.write : req0.write;
        addrPhase.HADDR  = grant1 ? req1.addr : req0.addr;
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            // Master 0 wins the first contention
            lastGrant1 <= 1'b1;
        end else if (grant0 | grant1) begin
            lastGrant1 <= grant1;
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataActive <= 1'b0;
            dataOwner  <= 1'b0;
            dataWrite  <= 1'b0;
        end else begin
            dataActive <= grant0 | grant1;
            dataOwner  <= grant1;
            dataWrite  <= addrPhase.HWRITE;
        end
    end

    // Write data comes from the master that owns the data phase
    assign HWDATA = dataOwner ? req1.wdata : req0.wdata;

    assign rdValid0 = dataActive & ~dataWrite & ~dataOwner;
    assign rdValid1 = dataActive & ~dataWrite & dataOwner;

endmodule

`default_nettype wire

/* rtl/ahbMacros.svh */
// Address width, RAM and FIFO depths, IO address map and mismatch filler word
`ifndef AHB_MACROS_SVH
`define AHB_MACROS_SVH

// Bus address width
`define AHB_ADDR_W 32

// RAM slave depth in 32-bit words
`define RAM_WORDS 256

// Replay record FIFO and IO write log depths
`define REPLAY_DEPTH 16
`define WLOG_DEPTH 16

// IO region starts here, HADDR bit 31 set
`define IO_BASE 32'h8000_0000

// Returned on a read with no matching record
`define FILLER_WORD 32'hDEAD_BEEF

`endif

/* rtl/ahbPkg.sv */
// Package with master request, address phase, IO record and interrupt structs
`default_nettype none

`include "ahbMacros.svh"

package ahbPkg;

    // Request held by a master until its grant
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`AHB_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } masterReq_t;

    // Shared address phase driven by the arbiter
    typedef struct packed {
        logic                   HSEL;
        logic                   HTRANS;
        logic                   HWRITE;
        logic [`AHB_ADDR_W-1:0] HADDR;
    } ahbAddrPhase_t;

    // One recorded IO read to be replayed
    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] addr;
        logic [31:0]            data;
    } readRecord_t;

    // One logged IO write
    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] addr;
        logic [31:0]            data;
    } writeRecord_t;

    typedef struct packed {
        logic irq;
        logic fiq;
    } irqState_t;

endpackage

`default_nettype wire

/* rtl/ahbRam.sv */
// Word-addressed AHB-lite RAM slave with address-phase register
`timescale 1ns/1ps
`default_nettype none

`include "ahbMacros.svh"

module ahbRam (
    input  wire logic                  HCLK,
    input  wire logic                  reset,
    input  wire logic                  HSEL,
    input  wire ahbPkg::ahbAddrPhase_t addrPhase,
    input  wire logic [31:0]           HWDATA,
    output logic [31:0]                HRDATA
);

    localparam int IdxW = $clog2(`RAM_WORDS);

    logic [31:0]     mem [`RAM_WORDS];
    logic            dataActive;
    logic            dataWrite;
    logic [IdxW-1:0] dataIdx;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataActive <= 1'b0;
        end else begin
            dataActive <= HSEL & addrPhase.HTRANS;
        end
    end

    // Byte address to word index
    always_ff @(posedge HCLK) begin
        dataWrite <= addrPhase.HWRITE;
        dataIdx   <= addrPhase.HADDR[IdxW+1:2];
    end

    // Write lands at the end of the data phase, so a read in the next
    // data phase already sees it
    always_ff @(posedge HCLK) begin
        if (dataActive & dataWrite) begin
            mem[dataIdx] <= HWDATA;
        end
    end

    assign HRDATA = mem[dataIdx];

endmodule

`default_nettype wire

/* rtl/ahbSubsystem.sv */
// Top level joining the arbiter, address decoder, RAM slave and IO shim
`timescale 1ns/1ps
`default_nettype none

module ahbSubsystem (
    input  wire logic                  HCLK,
    input  wire logic                  reset,
    input  wire ahbPkg::masterReq_t    req0,
    input  wire ahbPkg::masterReq_t    req1,
    output logic                       grant0,
    output logic                       grant1,
    output logic                       rdValid0,
    output logic                       rdValid1,
    output logic [31:0]                HRDATA,
    input  wire logic                  recordPush,
    input  wire ahbPkg::readRecord_t   recordIn,
    input  wire logic                  irqSet,
    input  wire ahbPkg::irqState_t     irqIn,
    output ahbPkg::irqState_t          irqOut,
    output logic                       readMismatch,
    input  wire logic                  logPop,
    output ahbPkg::writeRecord_t       logHead,
    output logic                       logNotEmpty
);

    import ahbPkg::*;

    ahbAddrPhase_t addrPhase;
    logic [31:0]   HWDATA;
    logic          HSELRam;
    logic          HSELIo;
    logic [31:0]   HRDATARam;
    logic [31:0]   HRDATAIo;

    ahbArbiter i_ahbArbiter (
        .HCLK      (HCLK),
        .reset     (reset),
        .req0      (req0),
        .req1      (req1),
        .grant0    (grant0),
        .grant1    (grant1),
        .rdValid0  (rdValid0),
        .rdValid1  (rdValid1),
        .addrPhase (addrPhase),
        .HWDATA    (HWDATA)
    );

    ahbAddrDecoder i_ahbAddrDecoder (
        .HCLK      (HCLK),
        .reset     (reset),
        .addrPhase (addrPhase),
        .HSELRam   (HSELRam),
        .HSELIo    (HSELIo),
        .HRDATARam (HRDATARam),
        .HRDATAIo  (HRDATAIo),
        .HRDATA    (HRDATA)
    );

    ahbRam i_ahbRam (
        .HCLK      (HCLK),
        .reset     (reset),
        .HSEL      (HSELRam),
        .addrPhase (addrPhase),
        .HWDATA    (HWDATA),
        .HRDATA    (HRDATARam)
    );

    ioForwardShim i_ioForwardShim (
        .HCLK         (HCLK),
        .reset        (reset),
        .HSEL         (HSELIo),
        .addrPhase    (addrPhase),
        .HWDATA       (HWDATA),
        .HRDATA       (HRDATAIo),
        .recordPush   (recordPush),
        .recordIn     (recordIn),
        .irqSet       (irqSet),
        .irqIn        (irqIn),
        .irqOut       (irqOut),
        .readMismatch (readMismatch),
        .logPop       (logPop),
        .logHead      (logHead),
        .logNotEmpty  (logNotEmpty)
    );

endmodule

`default_nettype wire

/* rtl/ioForwardShim.sv */
// IO slave with recorded read replay, write log FIFO and interrupt outputs
`timescale 1ns/1ps
`default_nettype none

`include "ahbMacros.svh"

module ioForwardShim (
    input  wire logic                  HCLK,
    input  wire logic                  reset,
    input  wire logic                  HSEL,
    input  wire ahbPkg::ahbAddrPhase_t addrPhase,
    input  wire logic [31:0]           HWDATA,
    output logic [31:0]                HRDATA,
    input  wire logic                  recordPush,
    input  wire ahbPkg::readRecord_t   recordIn,
    input  wire logic                  irqSet,
    input  wire ahbPkg::irqState_t     irqIn,
    output ahbPkg::irqState_t          irqOut,
    output logic                       readMismatch,
    input  wire logic                  logPop,
    output ahbPkg::writeRecord_t       logHead,
    output logic                       logNotEmpty
);

    import ahbPkg::*;

    logic                   dataActive;
    logic                   dataWrite;
    logic [`AHB_ADDR_W-1:0] dataAddr;

    readRecord_t  replayHead;
    logic         replayNotEmpty;
    logic         replayFull;
    logic         replayPop;
    logic         replayHit;
    logic         dataRead;
    writeRecord_t logEntry;
    logic         logPush;
    logic         logFull;

    always_ff @(posedge HCLK) begin
        if (reset) begin
            dataActive <= 1'b0;
        end else begin
            dataActive <= HSEL & addrPhase.HTRANS;
        end
    end

    always_ff @(posedge HCLK) begin
        dataWrite <= addrPhase.HWRITE;
        dataAddr  <= addrPhase.HADDR;
    end

    recordFifo #(
        .payloadT (readRecord_t),
        .DEPTH    (`REPLAY_DEPTH)
    ) replayFifo (
        .HCLK     (HCLK),
        .reset    (reset),
        .push     (recordPush & ~replayFull),
        .pushData (recordIn),
        .pop      (replayPop),
        .headData (replayHead),
        .notEmpty (replayNotEmpty),
        .full     (replayFull)
    );

    // Only a read at the head's address consumes the record
    assign dataRead     = dataActive & ~dataWrite;
    assign replayHit    = replayNotEmpty & (replayHead.addr == dataAddr);
    assign replayPop    = dataRead & replayHit;
    assign readMismatch = dataRead & ~replayHit;
    assign HRDATA       = replayHit ? replayHead.data : `FILLER_WORD;

    // Writes past a full log are lost
    assign logEntry.addr = dataAddr;
    assign logEntry.data = HWDATA;
    assign logPush       = dataActive & dataWrite & ~logFull;

    recordFifo #(
        .payloadT (writeRecord_t),
        .DEPTH    (`WLOG_DEPTH)
    ) writeLog (
        .HCLK     (HCLK),
        .reset    (reset),
        .push     (logPush),
        .pushData (logEntry),
        .pop      (logPop),
        .headData (logHead),
        .notEmpty (logNotEmpty),
        .full     (logFull)
    );

    always_ff @(posedge HCLK) begin
        if (reset) begin
            irqOut <= '0;
        end else if (irqSet) begin
            irqOut <= irqIn;
        end
    end

endmodule

`default_nettype wire

/* rtl/recordFifo.sv */
// Synchronous circular-buffer FIFO with a type-parameterized payload
`timescale 1ns/1ps
`default_nettype none

module recordFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  DEPTH    = 16
) (
    input  wire logic    HCLK,
    input  wire logic    reset,
    input  wire logic    push,
    input  wire payloadT pushData,
    input  wire logic    pop,
    output payloadT      headData,
    output logic         notEmpty,
    output logic         full
);

    localparam int PtrW   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CountW = $clog2(DEPTH + 1);

    payloadT            mem [DEPTH];
    logic [PtrW-1:0]    rdPtr;
    logic [PtrW-1:0]    wrPtr;
    logic [CountW-1:0]  count;
    logic               doPush;
    logic               doPop;

    assign notEmpty = (count != '0);
    assign full     = (count == CountW'(DEPTH));
    assign headData = mem[rdPtr];

    // Push is dropped when full, pop ignored when empty
    assign doPush = push & ~full;
    assign doPop  = pop & notEmpty;

    always_ff @(posedge HCLK) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            count <= count + CountW'(doPush) - CountW'(doPop);
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" &&
verilator --binary --timing -f src.f --top-module tbAhbSubsystem -o simAhbSubsystem &&
./obj_dir/simAhbSubsystem | tee /dev/stderr | grep -q "Simulation passed" ||
exit 1

/* sim/tbAhbSubsystem.sv */
// Testbench for the AHB-lite subsystem with reference model, compare process and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "ahbMacros.svh"

module tbAhbSubsystem;

    import ahbPkg::*;

    typedef struct packed {
        logic        owner;
        logic        mismatch;
        logic [31:0] data;
    } expRead_t;

    localparam int NumTests      = 6;
    localparam int TimeoutCycles = 400 * NumTests;

    logic         HCLK;
    logic         reset;
    masterReq_t   req [2];
    wire  [1:0]   grant;
    wire  [1:0]   rdValid;
    logic [31:0]  HRDATA;
    logic         recordPush;
    readRecord_t  recordIn;
    logic         irqSet;
    irqState_t    irqIn;
    irqState_t    irqOut;
    logic         readMismatch;
    logic         logPop;
    writeRecord_t logHead;
    logic         logNotEmpty;

    // Reference model state
    logic [31:0]  refRam [`RAM_WORDS];
    readRecord_t  replayQ [$];
    writeRecord_t logQ [$];
    expRead_t     expQ [$];
    logic         rrLast1;

    masterReq_t   opQ [2][$];
    logic [1:0]   masterBusy;
    int           grantLog [$];
    int           waitLog [$];
    logic [31:0]  ramAddrs [$];
    logic [31:0]  rngState;
    int           checks;
    int           errors;
    int           mismatchSeen;
    string        curTest;
    logic [1:0]   expGrant;
    expRead_t     expEntry;

    tbClockGen clockGen (
        .HCLK  (HCLK),
        .reset (reset)
    );

    ahbSubsystem i_ahbSubsystem (
        .HCLK         (HCLK),
        .reset        (reset),
        .req0         (req[0]),
        .req1         (req[1]),
        .grant0       (grant[0]),
        .grant1       (grant[1]),
        .rdValid0     (rdValid[0]),
        .rdValid1     (rdValid[1]),
        .HRDATA       (HRDATA),
        .recordPush   (recordPush),
        .recordIn     (recordIn),
        .irqSet       (irqSet),
        .irqIn        (irqIn),
        .irqOut       (irqOut),
        .readMismatch (readMismatch),
        .logPop       (logPop),
        .logHead      (logHead),
        .logNotEmpty  (logNotEmpty)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Expected {grant1, grant0} with contention won by the master not granted last
    function automatic logic [1:0] roundRobinGrant(input logic valid0, input logic valid1,
                                                   input logic last1);
        if (valid0 && valid1) begin
            return last1 ? 2'b01 : 2'b10;
        end
        return {valid1, valid0};
    endfunction

    // Expected {mismatch, data} of a read granted now
    function automatic logic [32:0] predictRead(input logic [31:0] addr);
        if (addr[31] == 1'b0) begin
            // Byte address bits 9:2 index the 256-word RAM
            return {1'b0, refRam[addr[9:2]]};
        end
        if (replayQ.size() != 0 && replayQ[0].addr == addr) begin
            return {1'b0, replayQ[0].data};
        end
        return {1'b1, `FILLER_WORD};
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("** Error %s, %s: expected %h, actual %h", curTest, what, expected, actual);
        end
    endtask

    task automatic reportProblem(input string what);
        errors++;
        $display("Problem in %s: %s", curTest, what);
    endtask

    task automatic afterEdge();
        @(posedge HCLK);
        #1;
    endtask

    task automatic startTest(input string name);
        @(negedge HCLK);
        curTest = name;
    endtask

    task automatic queueOp(input int m, input logic write, input logic [31:0] addr,
                           input logic [31:0] wdata);
        opQ[m].push_back({1'b1, write, addr, wdata});
    endtask

    // Returns once every queued transfer has been granted and every read checked
    task automatic waitIdle();
        do begin
            @(negedge HCLK);
        end while (opQ[0].size() != 0 || opQ[1].size() != 0 || masterBusy != 2'b00 ||
                   expQ.size() != 0);
        // Last write data phase, then its log entry
        repeat (2) @(negedge HCLK);
    endtask

    task automatic pushRecord(input logic [31:0] addr, input logic [31:0] data);
        afterEdge();
        recordPush = 1'b1;
        recordIn   = {addr, data};
        if (replayQ.size() < `REPLAY_DEPTH) begin
            replayQ.push_back({addr, data});
        end
        afterEdge();
        recordPush = 1'b0;
    endtask

    // Model update in grant order
    task automatic logGrant(input int m, input masterReq_t op, input int waitCycles);
        logic [32:0] rd;
        grantLog.push_back(m);
        waitLog.push_back(waitCycles);
        if (op.write) begin
            if (!op.addr[31]) begin
                refRam[op.addr[9:2]] = op.wdata;
            end else if (logQ.size() < `WLOG_DEPTH) begin
                logQ.push_back({op.addr, op.wdata});
            end
        end else begin
            rd = predictRead(op.addr);
            expQ.push_back(expRead_t'({1'(m), rd}));
            if (op.addr[31] && !rd[32]) begin
                void'(replayQ.pop_front());
            end
        end
    endtask

    task automatic drainLog();
        while (logQ.size() != 0) begin
            @(negedge HCLK);
            checkValue("log not empty", 64'd1, 64'(logNotEmpty));
            checkValue("log head", logQ[0], logHead);
            afterEdge();
            logPop = 1'b1;
            afterEdge();
            logPop = 1'b0;
            void'(logQ.pop_front());
        end
        @(negedge HCLK);
        checkValue("log empty", 64'd0, 64'(logNotEmpty));
    endtask

    task automatic setIrq(input irqState_t value);
        afterEdge();
        irqSet = 1'b1;
        irqIn  = value;
        afterEdge();
        irqSet = 1'b0;
        @(negedge HCLK);
        checkValue("irq out", 64'(value), 64'(irqOut));
    endtask

    // Each master holds its request until granted and gives write data in the data phase
    initial begin : masterDriver
        masterReq_t cur [2];
        logic       granted [2];
        int         waitCycles [2];
        for (int m = 0; m < 2; m++) begin
            req[m]        = '0;
            cur[m]        = '0;
            granted[m]    = 1'b0;
            waitCycles[m] = 0;
        end
        masterBusy = 2'b00;
        forever begin
            afterEdge();
            for (int m = 0; m < 2; m++) begin
                if (granted[m]) begin
                    req[m].wdata = cur[m].wdata;
                    req[m].valid = 1'b0;
                    granted[m]   = 1'b0;
                end
                if (!masterBusy[m] && opQ[m].size() != 0) begin
                    cur[m]        = opQ[m].pop_front();
                    req[m].valid  = 1'b1;
                    req[m].write  = cur[m].write;
                    req[m].addr   = cur[m].addr;
                    masterBusy[m] = 1'b1;
                    waitCycles[m] = 0;
                end
            end
            @(negedge HCLK);
            for (int m = 0; m < 2; m++) begin
                if (masterBusy[m] && grant[m]) begin
                    logGrant(m, cur[m], waitCycles[m]);
                    granted[m]    = 1'b1;
                    masterBusy[m] = 1'b0;
                end else if (masterBusy[m]) begin
                    waitCycles[m]++;
                end
            end
        end
    end

    // Grants checked every cycle and read data on each rdValid pulse
    always @(negedge HCLK) begin
        if (reset) begin
            rrLast1 = 1'b1;
        end else begin
            expGrant = roundRobinGrant(req[0].valid, req[1].valid, rrLast1);
            checkValue("grant", 64'(expGrant), 64'(grant));
            if (expGrant != 2'b00) begin
                rrLast1 = expGrant[1];
            end
            if (readMismatch) begin
                mismatchSeen++;
            end
            if (rdValid != 2'b00) begin
                assert (expQ.size() != 0) else begin
                    reportProblem("read data valid pulsed with no read outstanding");
                end
                if (expQ.size() != 0) begin
                    expEntry = expQ.pop_front();
                    checkValue("read owner", 64'(expEntry.owner ? 2'b10 : 2'b01),
                               64'(rdValid));
                    checkValue("read data", 64'(expEntry.data), 64'(HRDATA));
                    checkValue("read mismatch", 64'(expEntry.mismatch), 64'(readMismatch));
                end
            end else begin
                checkValue("idle mismatch", 64'd0, 64'(readMismatch));
            end
        end
    end

    initial begin : watchdog
        repeat (TimeoutCycles) @(posedge HCLK);
        $display("Timeout in %s: tests did not finish within %0d cycles", curTest,
                 TimeoutCycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin : mainSequence
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] recAddr [8];
        int          seenBefore;
        checks       = 0;
        errors       = 0;
        mismatchSeen = 0;
        rngState     = 32'h0bd1_7f22;
        curTest      = "reset state";
        recordPush   = 1'b0;
        recordIn     = '0;
        irqSet       = 1'b0;
        irqIn        = '0;
        logPop       = 1'b0;

        do begin
            @(negedge HCLK);
        end while (reset);
        checkValue("grant", 64'd0, 64'(grant));
        checkValue("rdValid", 64'd0, 64'(rdValid));
        checkValue("readMismatch", 64'd0, 64'(readMismatch));
        checkValue("irqOut", 64'd0, 64'(irqOut));
        checkValue("logNotEmpty", 64'd0, 64'(logNotEmpty));

        // Both masters contend from the first cycle after reset
        startTest("arbitration");
        grantLog.delete();
        for (int i = 0; i < 6; i++) begin
            queueOp(0, 1'b1, nextRandom() & 32'h0000_03FC, nextRandom());
            queueOp(1, 1'b1, nextRandom() & 32'h0000_03FC, nextRandom());
        end
        waitIdle();
        checkValue("grant count", 64'd12, 64'(grantLog.size()));
        for (int i = 0; i < 12; i++) begin
            checkValue("grant order", 64'(i % 2), 64'(grantLog[i]));
        end
        grantLog.delete();
        waitLog.delete();
        queueOp(1, 1'b1, nextRandom() & 32'h0000_03FC, nextRandom());
        waitIdle();
        checkValue("lone grant wait", 64'd0, 64'(waitLog[0]));

        startTest("RAM traffic");
        ramAddrs.delete();
        for (int i = 0; i < 40; i++) begin
            addr = nextRandom() & 32'h0000_03FC;
            queueOp(i % 2, 1'b1, addr, nextRandom());
            ramAddrs.push_back(addr);
        end
        waitIdle();
        @(negedge HCLK);
        for (int i = 0; i < 40; i++) begin
            queueOp(i % 2, 1'b0, ramAddrs[i], '0);
        end
        waitIdle();
        // Write then read of the same word on consecutive grants
        @(negedge HCLK);
        addr = nextRandom() & 32'h0000_03FC;
        data = nextRandom();
        queueOp(0, 1'b1, addr, data);
        queueOp(0, 1'b0, addr, '0);
        waitIdle();

        startTest("replay reads");
        for (int i = 0; i < 8; i++) begin
            recAddr[i] = `IO_BASE | (nextRandom() & 32'h0000_0FFC);
            pushRecord(recAddr[i], nextRandom());
        end
        @(negedge HCLK);
        seenBefore = mismatchSeen;
        for (int i = 0; i < 8; i++) begin
            queueOp(0, 1'b0, recAddr[i], '0);
        end
        waitIdle();
        checkValue("mismatch pulses", 64'd0, 64'(mismatchSeen - seenBefore));

        // Unrecorded address, a RAM read, both records, then an empty FIFO
        startTest("mismatches");
        recAddr[0] = `IO_BASE | (nextRandom() & 32'h0000_0FFC);
        pushRecord(recAddr[0], nextRandom());
        recAddr[1] = `IO_BASE | (nextRandom() & 32'h0000_0FFC);
        pushRecord(recAddr[1], nextRandom());
        @(negedge HCLK);
        seenBefore = mismatchSeen;
        queueOp(0, 1'b0, addr, '0);
        queueOp(1, 1'b0, `IO_BASE | 32'h0000_F000, '0);
        queueOp(1, 1'b0, recAddr[0], '0);
        queueOp(1, 1'b0, recAddr[1], '0);
        queueOp(1, 1'b0, recAddr[1], '0);
        waitIdle();
        checkValue("mismatch pulses", 64'd2, 64'(mismatchSeen - seenBefore));

        startTest("IO writes and irq");
        for (int i = 0; i < 6; i++) begin
            queueOp(i % 2, 1'b1, `IO_BASE | (nextRandom() & 32'h0000_0FFC), nextRandom());
        end
        waitIdle();
        drainLog();
        setIrq(2'b10);
        setIrq(2'b11);
        setIrq(2'b01);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tbClockGen.sv */
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 3
) (
    output logic HCLK,
    output logic reset
);

    initial begin
        HCLK = 1'b0;
        forever #(halfPeriod) HCLK = ~HCLK;
    end

    // Reset released just after the last reset edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge HCLK);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/ahbPkg.sv
rtl/recordFifo.sv
rtl/ahbArbiter.sv
rtl/ahbAddrDecoder.sv
rtl/ahbRam.sv
rtl/ioForwardShim.sv
rtl/ahbSubsystem.sv
sim/tbClockGen.sv
sim/tbAhbSubsystem.sv
